//--- logic/qdrc_defs.svh
`ifndef QDRC_DEFS_SVH
`define QDRC_DEFS_SVH

// width of one data beat on the d and q buses.
`define QDRC_DATA_WIDTH 18

// byte write lanes per beat, 9 bits each.
`define QDRC_BW_WIDTH 2

// word address width.
`define QDRC_ADDR_WIDTH 21

// word written to address 0 and read back during calibration.
`define QDRC_CAL_PATTERN 36'h5_a5a5_a5a5

// longest read return the phy will wait for, in cycles.
`define QDRC_CAL_MAX_LAT 15

// enough bits to count up to the maximum latency.
`define QDRC_LAT_WIDTH 4

`endif

//--- logic/qdrc_mem_pkg.sv
`include "qdrc_defs.svh"

package qdrc_mem_pkg;

  typedef logic [`QDRC_DATA_WIDTH-1:0] qdr_beat_t; // one beat, rise or fall.
  typedef logic [`QDRC_BW_WIDTH-1:0]   qdr_bw_t;   // active low lane mask of one beat.
  typedef logic [`QDRC_ADDR_WIDTH-1:0] qdr_addr_t; // word address.

  // operation seen by the sram in one cycle.
  typedef enum logic [1:0] {
    op_nop,
    op_write,
    op_read
  } qdr_op_t;

  typedef enum logic [2:0] {
    cal_reset,
    cal_write,
    cal_read,
    cal_wait,
    cal_done,
    cal_error
  } cal_state_t;

endpackage

//--- logic/qdrc_usr_pkg.sv
`include "qdrc_defs.svh"

package qdrc_usr_pkg;

  typedef logic [2*`QDRC_DATA_WIDTH-1:0] usr_word_t; // rise beat in the low half.
  typedef logic [2*`QDRC_BW_WIDTH-1:0]   usr_be_t;   // active high, one bit per 9 bits.

  typedef enum logic {
    cmd_write,
    cmd_read
  } usr_cmd_t;

endpackage

//--- logic/qdrc_wr.sv
`timescale 1ns/1ns
`include "qdrc_defs.svh"

module qdrc_wr (
  input  logic                         clk0,
  input  logic                         reset,
  input  logic                         phy_rdy,
  input  logic                         usr_wr_strb,
  input  qdrc_mem_pkg::qdr_addr_t      usr_addr,
  input  qdrc_usr_pkg::usr_word_t      usr_wr_data,
  input  qdrc_usr_pkg::usr_be_t        usr_wr_be,
  output logic                         wr_strb,
  output qdrc_mem_pkg::qdr_addr_t      wr_addr,
  output qdrc_usr_pkg::usr_word_t      wr_data,
  output logic [2*`QDRC_BW_WIDTH-1:0]  wr_bw_n
);

  // this stage only ever carries qdrc_usr_pkg::cmd_write requests.
  logic accept;

  // writes before the phy is ready are dropped.
  assign accept = usr_wr_strb & phy_rdy;

  always_ff @(posedge clk0) begin
    if (reset) begin
      wr_strb <= 1'b0;
    end else begin
      wr_strb <= accept;
    end
  end

  // payload follows the strobe.
  always_ff @(posedge clk0) begin
    if (accept) begin
      wr_addr <= usr_addr;
      wr_data <= usr_wr_data;
      // low pair masks the rise beat, high pair the fall beat.
      wr_bw_n <= {~usr_wr_be[2*`QDRC_BW_WIDTH-1:`QDRC_BW_WIDTH],
                  ~usr_wr_be[`QDRC_BW_WIDTH-1:0]};
    end
  end

endmodule

//--- logic/qdrc_rd.sv
`timescale 1ns/1ns

module qdrc_rd (
  input  logic                     clk0,
  input  logic                     reset,
  input  logic                     phy_rdy,
  input  logic                     usr_rd_strb,
  input  qdrc_mem_pkg::qdr_addr_t  usr_addr,
  output logic                     rd_strb,
  output qdrc_mem_pkg::qdr_addr_t  rd_addr,
  input  qdrc_usr_pkg::usr_word_t  rd_data,
  input  logic                     rd_dvld,
  output qdrc_usr_pkg::usr_word_t  usr_rd_data,
  output logic                     usr_rd_dvld
);

  // this stage only ever carries qdrc_usr_pkg::cmd_read requests.
  logic accept;

  assign accept = usr_rd_strb & phy_rdy;

  // ********************************************************************
  // request toward the phy
  // ********************************************************************

  always_ff @(posedge clk0) begin
    if (reset) begin
      rd_strb <= 1'b0;
    end else begin
      rd_strb <= accept; // one request per cycle, no back-pressure.
    end
  end

  always_ff @(posedge clk0) begin
    if (accept) rd_addr <= usr_addr;
  end

  // returned data, one cycle after the phy capture.
  always_ff @(posedge clk0) begin
    if (reset) begin
      usr_rd_dvld <= 1'b0;
    end else begin
      usr_rd_dvld <= rd_dvld;
    end
  end

  always_ff @(posedge clk0) begin
    if (rd_dvld) usr_rd_data <= rd_data;
  end

endmodule

//--- logic/qdrc_phy.sv
`timescale 1ns/1ns
`include "qdrc_defs.svh"

module qdrc_phy (
  input  logic                         clk0,
  input  logic                         reset,
  input  logic                         wr_strb,
  input  qdrc_mem_pkg::qdr_addr_t      wr_addr,
  input  qdrc_usr_pkg::usr_word_t      wr_data,
  input  logic [2*`QDRC_BW_WIDTH-1:0]  wr_bw_n,
  input  logic                         rd_strb,
  input  qdrc_mem_pkg::qdr_addr_t      rd_addr,
  output qdrc_usr_pkg::usr_word_t      rd_data,
  output logic                         rd_dvld,
  output logic                         phy_rdy,
  output logic                         cal_fail,
  output qdrc_mem_pkg::qdr_beat_t      qdr_d_rise,
  output qdrc_mem_pkg::qdr_beat_t      qdr_d_fall,
  input  qdrc_mem_pkg::qdr_beat_t      qdr_q_rise,
  input  qdrc_mem_pkg::qdr_beat_t      qdr_q_fall,
  output qdrc_mem_pkg::qdr_addr_t      qdr_sa,
  output logic                         qdr_w_n,
  output logic                         qdr_r_n,
  output logic                         qdr_dll_off_n,
  output qdrc_mem_pkg::qdr_bw_t        qdr_bw_n_rise,
  output qdrc_mem_pkg::qdr_bw_t        qdr_bw_n_fall
);

  qdrc_mem_pkg::cal_state_t        cal_state;
  qdrc_mem_pkg::qdr_op_t           cal_op;
  logic [`QDRC_LAT_WIDTH-1:0]      lat_cnt;
  logic [`QDRC_LAT_WIDTH-1:0]      cal_lat;
  logic [`QDRC_CAL_MAX_LAT:0]      rd_pipe;   // bit i set i cycles after r_n low.
  logic                            cal_match;
  logic                            rd_issue;
  logic                            wr_issue;
  logic                            pend_vld;
  qdrc_mem_pkg::qdr_addr_t         pend_addr;
  qdrc_usr_pkg::usr_word_t         pend_data;
  logic [2*`QDRC_BW_WIDTH-1:0]     pend_bw_n;
  qdrc_mem_pkg::qdr_addr_t         rd_addr_sel;
  qdrc_mem_pkg::qdr_addr_t         wr_addr_sel;
  qdrc_usr_pkg::usr_word_t         wr_data_sel;
  logic [2*`QDRC_BW_WIDTH-1:0]     wr_bw_n_sel;

  assign phy_rdy   = (cal_state == qdrc_mem_pkg::cal_done);
  assign cal_fail  = (cal_state == qdrc_mem_pkg::cal_error);
  assign cal_match = ({qdr_q_fall, qdr_q_rise} == `QDRC_CAL_PATTERN);

  // ********************************************************************
  // calibration
  // ********************************************************************

  always_ff @(posedge clk0) begin
    if (reset) begin
      cal_state     <= qdrc_mem_pkg::cal_reset;
      lat_cnt       <= '0;
      cal_lat       <= '0;
      qdr_dll_off_n <= 1'b0;
    end else begin
      case (cal_state)
        qdrc_mem_pkg::cal_reset: begin
          qdr_dll_off_n <= 1'b1; // dll on as calibration starts.
          cal_state     <= qdrc_mem_pkg::cal_write;
        end
        qdrc_mem_pkg::cal_write: cal_state <= qdrc_mem_pkg::cal_read;
        qdrc_mem_pkg::cal_read: begin
          lat_cnt   <= '0; // count 0 is the cycle r_n is low.
          cal_state <= qdrc_mem_pkg::cal_wait;
        end
        qdrc_mem_pkg::cal_wait: begin
          if (cal_match) begin
            cal_lat   <= lat_cnt;
            cal_state <= qdrc_mem_pkg::cal_done;
          end else if (lat_cnt == `QDRC_LAT_WIDTH'(`QDRC_CAL_MAX_LAT)) begin
            cal_state <= qdrc_mem_pkg::cal_error;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        default: ; // done and error hold until reset.
      endcase
    end
  end

  always_comb begin
    case (cal_state)
      qdrc_mem_pkg::cal_write: cal_op = qdrc_mem_pkg::op_write;
      qdrc_mem_pkg::cal_read:  cal_op = qdrc_mem_pkg::op_read;
      default:                 cal_op = qdrc_mem_pkg::op_nop;
    endcase
  end

  // ********************************************************************
  // command issue
  // ********************************************************************

  // a read always goes at once and pushes a same-cycle write back by one.
  assign rd_issue = phy_rdy ? rd_strb : (cal_op == qdrc_mem_pkg::op_read);
  assign wr_issue = phy_rdy ? ((pend_vld | wr_strb) & ~rd_strb)
                            : (cal_op == qdrc_mem_pkg::op_write);

  always_comb begin
    rd_addr_sel = phy_rdy ? rd_addr : '0;
    if (!phy_rdy) begin
      wr_addr_sel = '0; // pattern goes to address 0, all lanes.
      wr_data_sel = `QDRC_CAL_PATTERN;
      wr_bw_n_sel = '0;
    end else if (pend_vld) begin
      wr_addr_sel = pend_addr;
      wr_data_sel = pend_data;
      wr_bw_n_sel = pend_bw_n;
    end else begin
      wr_addr_sel = wr_addr;
      wr_data_sel = wr_data;
      wr_bw_n_sel = wr_bw_n;
    end
  end

  always_ff @(posedge clk0) begin
    if (reset) begin
      pend_vld <= 1'b0;
    end else if (phy_rdy) begin
      pend_vld <= rd_strb ? (pend_vld | wr_strb) : (pend_vld & wr_strb);
    end
  end

  always_ff @(posedge clk0) begin
    if (wr_strb && (rd_strb ? !pend_vld : pend_vld)) begin
      pend_addr <= wr_addr;
      pend_data <= wr_data;
      pend_bw_n <= wr_bw_n;
    end
  end

  always_ff @(posedge clk0) begin
    if (reset) begin
      qdr_w_n <= 1'b1;
      qdr_r_n <= 1'b1;
    end else begin
      qdr_w_n <= ~wr_issue;
      qdr_r_n <= ~rd_issue;
    end
  end

  always_ff @(posedge clk0) begin
    qdr_sa        <= rd_issue ? rd_addr_sel : wr_addr_sel;
    qdr_d_rise    <= wr_data_sel[`QDRC_DATA_WIDTH-1:0];
    qdr_d_fall    <= wr_data_sel[2*`QDRC_DATA_WIDTH-1:`QDRC_DATA_WIDTH];
    qdr_bw_n_rise <= wr_bw_n_sel[`QDRC_BW_WIDTH-1:0];
    qdr_bw_n_fall <= wr_bw_n_sel[2*`QDRC_BW_WIDTH-1:`QDRC_BW_WIDTH];
  end

  // ********************************************************************
  // read capture
  // ********************************************************************

  always_ff @(posedge clk0) begin
    if (reset) begin
      rd_pipe <= '0;
      rd_dvld <= 1'b0;
    end else begin
      rd_pipe <= {rd_pipe[`QDRC_CAL_MAX_LAT-1:0], rd_issue};
      rd_dvld <= phy_rdy & rd_pipe[cal_lat]; // the calibration read is not returned.
    end
  end

  always_ff @(posedge clk0) begin
    if (rd_pipe[cal_lat]) rd_data <= {qdr_q_fall, qdr_q_rise};
  end

endmodule

//--- logic/qdrc_top.sv
`timescale 1ns/1ns
`include "qdrc_defs.svh"

module qdrc_top (
  input  logic                     clk0,
  input  logic                     reset,
  output qdrc_mem_pkg::qdr_beat_t  qdr_d_rise,
  output qdrc_mem_pkg::qdr_beat_t  qdr_d_fall,
  input  qdrc_mem_pkg::qdr_beat_t  qdr_q_rise,
  input  qdrc_mem_pkg::qdr_beat_t  qdr_q_fall,
  output qdrc_mem_pkg::qdr_addr_t  qdr_sa,
  output logic                     qdr_w_n,
  output logic                     qdr_r_n,
  output logic                     qdr_dll_off_n,
  output qdrc_mem_pkg::qdr_bw_t    qdr_bw_n_rise,
  output qdrc_mem_pkg::qdr_bw_t    qdr_bw_n_fall,
  output logic                     phy_rdy,
  output logic                     cal_fail,
  input  logic                     usr_rd_strb,
  input  logic                     usr_wr_strb,
  input  qdrc_mem_pkg::qdr_addr_t  usr_addr,
  output qdrc_usr_pkg::usr_word_t  usr_rd_data,
  output logic                     usr_rd_dvld,
  input  qdrc_usr_pkg::usr_word_t  usr_wr_data,
  input  qdrc_usr_pkg::usr_be_t    usr_wr_be
);

  logic                         reset_retimed;
  logic                         wr_strb;
  qdrc_mem_pkg::qdr_addr_t      wr_addr;
  qdrc_usr_pkg::usr_word_t      wr_data;
  logic [2*`QDRC_BW_WIDTH-1:0]  wr_bw_n;
  logic                         rd_strb;
  qdrc_mem_pkg::qdr_addr_t      rd_addr;
  qdrc_usr_pkg::usr_word_t      rd_data;
  logic                         rd_dvld;

  // ********************************************************************
  // reset retiming
  // ********************************************************************

  always_ff @(posedge clk0) begin
    reset_retimed <= reset; // whole controller sees reset one cycle late.
  end

  qdrc_phy qdrc_phy_inst (
    .clk0          (clk0),
    .reset         (reset_retimed),
    .wr_strb       (wr_strb),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_bw_n       (wr_bw_n),
    .rd_strb       (rd_strb),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .rd_dvld       (rd_dvld),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .qdr_d_rise    (qdr_d_rise),
    .qdr_d_fall    (qdr_d_fall),
    .qdr_q_rise    (qdr_q_rise),
    .qdr_q_fall    (qdr_q_fall),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_dll_off_n (qdr_dll_off_n),
    .qdr_bw_n_rise (qdr_bw_n_rise),
    .qdr_bw_n_fall (qdr_bw_n_fall)
  );

  // both user stages share the one user address.
  qdrc_wr qdrc_wr_inst (
    .clk0        (clk0),
    .reset       (reset_retimed),
    .phy_rdy     (phy_rdy),
    .usr_wr_strb (usr_wr_strb),
    .usr_addr    (usr_addr),
    .usr_wr_data (usr_wr_data),
    .usr_wr_be   (usr_wr_be),
    .wr_strb     (wr_strb),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_bw_n     (wr_bw_n)
  );

  qdrc_rd qdrc_rd_inst (
    .clk0        (clk0),
    .reset       (reset_retimed),
    .phy_rdy     (phy_rdy),
    .usr_rd_strb (usr_rd_strb),
    .usr_addr    (usr_addr),
    .rd_strb     (rd_strb),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_dvld     (rd_dvld),
    .usr_rd_data (usr_rd_data),
    .usr_rd_dvld (usr_rd_dvld)
  );

endmodule

//--- dv/qdr_sram_model.sv
`timescale 1ns/1ns
`include "qdrc_defs.svh"

module qdr_sram_model #(
  parameter int lat = 3 // cycles from r_n low to data on q.
) (
  input  logic                         clk0,
  input  logic [`QDRC_ADDR_WIDTH-1:0]  qdr_sa,
  input  logic                         qdr_w_n,
  input  logic                         qdr_r_n,
  input  logic [`QDRC_DATA_WIDTH-1:0]  qdr_d_rise,
  input  logic [`QDRC_DATA_WIDTH-1:0]  qdr_d_fall,
  input  logic [`QDRC_BW_WIDTH-1:0]    qdr_bw_n_rise,
  input  logic [`QDRC_BW_WIDTH-1:0]    qdr_bw_n_fall,
  output logic [`QDRC_DATA_WIDTH-1:0]  qdr_q_rise,
  output logic [`QDRC_DATA_WIDTH-1:0]  qdr_q_fall
);

  localparam int word_w = 2 * `QDRC_DATA_WIDTH;
  localparam int lane_w = `QDRC_DATA_WIDTH / `QDRC_BW_WIDTH;
  localparam int lanes  = 2 * `QDRC_BW_WIDTH;

  logic [word_w-1:0]      mem [0:(1 << `QDRC_ADDR_WIDTH) - 1];
  logic [word_w-1:0]      q_pipe [0:lat-1]; // last stage drives the q pins.
  qdrc_mem_pkg::qdr_op_t  rd_port_op;
  qdrc_mem_pkg::qdr_op_t  wr_port_op;

  // lanes with a low mask bit take the new data.
  function automatic logic [word_w-1:0] merge_lanes(
    input logic [word_w-1:0] old_word,
    input logic [word_w-1:0] new_word,
    input logic [lanes-1:0]  bw_n
  );
    logic [word_w-1:0] merged;
    merged = old_word;
    for (int i = 0; i < lanes; i++) begin
      if (!bw_n[i]) merged[i*lane_w +: lane_w] = new_word[i*lane_w +: lane_w];
    end
    return merged;
  endfunction

  // separate read and write ports.
  assign rd_port_op = (qdr_r_n == 1'b0) ? qdrc_mem_pkg::op_read : qdrc_mem_pkg::op_nop;
  assign wr_port_op = (qdr_w_n == 1'b0) ? qdrc_mem_pkg::op_write : qdrc_mem_pkg::op_nop;

  always_ff @(posedge clk0) begin
    if (wr_port_op == qdrc_mem_pkg::op_write) begin
      mem[qdr_sa] <= merge_lanes(mem[qdr_sa], {qdr_d_fall, qdr_d_rise},
                                 {qdr_bw_n_fall, qdr_bw_n_rise});
    end
    // a read in the same cycle sees the word from before the write.
    q_pipe[0] <= (rd_port_op == qdrc_mem_pkg::op_read) ? mem[qdr_sa] : '0;
    for (int i = 1; i < lat; i++) begin
      q_pipe[i] <= q_pipe[i-1];
    end
  end

  assign {qdr_q_fall, qdr_q_rise} = q_pipe[lat-1];

endmodule

//--- dv/qdrc_checker.sv
`timescale 1ns/1ns

module qdrc_checker (
  input logic clk0,
  input logic reset,
  input logic phy_rdy,
  input logic cal_fail,
  input logic qdr_w_n,
  input logic qdr_r_n,
  input logic qdr_dll_off_n,
  input logic usr_rd_dvld
);

  logic       rd_issued;      // a user read on the sram pins.
  logic [7:0] rd_outstanding; // user reads on the pins not yet returned.
  int         assert_errors = 0;

  assign rd_issued = !qdr_r_n && phy_rdy;

  always_ff @(posedge clk0) begin
    if (reset) begin
      rd_outstanding <= '0;
    end else if (rd_issued && !usr_rd_dvld) begin
      rd_outstanding <= rd_outstanding + 1'b1;
    end else if (!rd_issued && usr_rd_dvld) begin
      rd_outstanding <= rd_outstanding - 1'b1;
    end
  end

  // ********************************************************************
  // properties
  // ********************************************************************

  // reset is retimed inside the top, so outputs settle after two reset cycles.
  reset_idle: assert property (@(posedge clk0) reset ##1 reset |=>
      (qdr_w_n && qdr_r_n && !qdr_dll_off_n && !phy_rdy && !cal_fail && !usr_rd_dvld))
    else begin
      assert_errors++;
      $error("controller outputs not idle during reset");
    end

  status_exclusive: assert property (@(posedge clk0) disable iff (reset)
      !(phy_rdy && cal_fail))
    else begin
      assert_errors++;
      $error("phy_rdy and cal_fail high together");
    end

  dvld_needs_rdy: assert property (@(posedge clk0) disable iff (reset)
      usr_rd_dvld |-> phy_rdy)
    else begin
      assert_errors++;
      $error("usr_rd_dvld high while phy_rdy is low");
    end

  dvld_after_read: assert property (@(posedge clk0) disable iff (reset)
      usr_rd_dvld |-> (rd_outstanding != '0))
    else begin
      assert_errors++;
      $error("usr_rd_dvld high with no user read outstanding at the sram");
    end

endmodule

//--- dv/qdrc_tb.sv
`timescale 1ns/1ns
`include "qdrc_defs.svh"

module qdrc_tb;

  localparam int max_tests = 64;

  logic                     clk0 = 1'b0;
  logic                     reset;
  logic                     usr_rd_strb;
  logic                     usr_wr_strb;
  qdrc_mem_pkg::qdr_addr_t  usr_addr;
  qdrc_usr_pkg::usr_word_t  usr_wr_data;
  qdrc_usr_pkg::usr_be_t    usr_wr_be;
  qdrc_usr_pkg::usr_word_t  usr_rd_data;
  logic                     usr_rd_dvld;
  logic                     phy_rdy;
  logic                     cal_fail;
  qdrc_mem_pkg::qdr_beat_t  qdr_d_rise;
  qdrc_mem_pkg::qdr_beat_t  qdr_d_fall;
  qdrc_mem_pkg::qdr_beat_t  qdr_q_rise;
  qdrc_mem_pkg::qdr_beat_t  qdr_q_fall;
  qdrc_mem_pkg::qdr_addr_t  qdr_sa;
  logic                     qdr_w_n;
  logic                     qdr_r_n;
  logic                     qdr_dll_off_n;
  qdrc_mem_pkg::qdr_bw_t    qdr_bw_n_rise;
  qdrc_mem_pkg::qdr_bw_t    qdr_bw_n_fall;

  // test table as read from the data file.
  string                    t_name [max_tests];
  byte                      t_op   [max_tests];
  qdrc_mem_pkg::qdr_addr_t  t_addr [max_tests];
  qdrc_usr_pkg::usr_word_t  t_data [max_tests];
  qdrc_usr_pkg::usr_be_t    t_be   [max_tests];
  qdrc_usr_pkg::usr_word_t  t_exp  [max_tests];
  int                       n_tests = 0;

  qdrc_usr_pkg::usr_word_t  exp_q [$]; // expected words in issue order.
  string                    name_q [$];
  int                       errors = 0;
  int                       reads_checked = 0;
  int                       stray_beats = 0;
  logic                     loaded = 1'b0;
  logic                     zero_written = 1'b0; // address 0 still holds the cal word.
  logic                     cal_bad = 1'b0;

  qdrc_top dut (
    .clk0          (clk0),
    .reset         (reset),
    .qdr_d_rise    (qdr_d_rise),
    .qdr_d_fall    (qdr_d_fall),
    .qdr_q_rise    (qdr_q_rise),
    .qdr_q_fall    (qdr_q_fall),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_dll_off_n (qdr_dll_off_n),
    .qdr_bw_n_rise (qdr_bw_n_rise),
    .qdr_bw_n_fall (qdr_bw_n_fall),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .usr_rd_strb   (usr_rd_strb),
    .usr_wr_strb   (usr_wr_strb),
    .usr_addr      (usr_addr),
    .usr_rd_data   (usr_rd_data),
    .usr_rd_dvld   (usr_rd_dvld),
    .usr_wr_data   (usr_wr_data),
    .usr_wr_be     (usr_wr_be)
  );

  qdr_sram_model #(.lat (3)) sram (
    .clk0          (clk0),
    .qdr_sa        (qdr_sa),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_d_rise    (qdr_d_rise),
    .qdr_d_fall    (qdr_d_fall),
    .qdr_bw_n_rise (qdr_bw_n_rise),
    .qdr_bw_n_fall (qdr_bw_n_fall),
    .qdr_q_rise    (qdr_q_rise),
    .qdr_q_fall    (qdr_q_fall)
  );

  bind qdrc_top qdrc_checker qdrc_checker_inst (
    .clk0          (clk0),
    .reset         (reset),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .qdr_w_n       (qdr_w_n),
    .qdr_r_n       (qdr_r_n),
    .qdr_dll_off_n (qdr_dll_off_n),
    .usr_rd_dvld   (usr_rd_dvld)
  );

  always #10 clk0 = ~clk0; // 20 ns period.

  // ********************************************************************
  // helpers
  // ********************************************************************

  task automatic load_tests();
    int           fd;
    int           fields;
    string        line;
    string        name;
    string        op_s;
    logic [63:0]  addr;
    logic [63:0]  data;
    logic [63:0]  be;
    logic [63:0]  exp_word;
    fd = $fopen("dv/qdrc_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/qdrc_tests.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue; // blank or column notes.
        fields = $sscanf(line, "%s %s %h %h %h %h", name, op_s, addr, data, be, exp_word);
        if (fields == 6 && n_tests < max_tests) begin
          t_name[n_tests] = name;
          t_op[n_tests]   = op_s[0];
          t_addr[n_tests] = addr[`QDRC_ADDR_WIDTH-1:0];
          t_data[n_tests] = data[2*`QDRC_DATA_WIDTH-1:0];
          t_be[n_tests]   = be[2*`QDRC_BW_WIDTH-1:0];
          t_exp[n_tests]  = exp_word[2*`QDRC_DATA_WIDTH-1:0];
          n_tests++;
        end else begin
          $display("test file line could not be used: %s", line);
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_bit(input string sig, input logic got, input logic want);
    if (got !== want) begin
      $display("Mismatch during reset: %s expected %h got %h", sig, want, got);
      errors++;
    end
  endtask

  task automatic wait_ready();
    while (!phy_rdy && !cal_fail) @(posedge clk0);
    if (cal_fail) begin
      $display("calibration failed, cal_fail rose instead of phy_rdy");
      errors++;
      cal_bad = 1'b1;
    end else if (qdr_dll_off_n !== 1'b1) begin
      $display("Mismatch after calibration: qdr_dll_off_n expected 1 got %h", qdr_dll_off_n);
      errors++;
    end
  endtask

  task automatic check_read(input qdrc_usr_pkg::usr_word_t got);
    qdrc_usr_pkg::usr_word_t want;
    string                   name;
    if (exp_q.size() == 0) begin
      $display("read data %h came back with no read outstanding", got);
      stray_beats++;
      errors++;
    end else begin
      want = exp_q.pop_front();
      name = name_q.pop_front();
      reads_checked++;
      if (got !== want) begin
        $display("Mismatch in %s: usr_rd_data expected %h got %h", name, want, got);
        errors++;
        $display("test %s: failed", name);
      end else begin
        $display("test %s: passed", name);
      end
    end
  endtask

  task automatic run_test(input int i);
    qdrc_usr_pkg::usr_cmd_t cmd;
    cmd = (t_op[i] == "W") ? qdrc_usr_pkg::cmd_write : qdrc_usr_pkg::cmd_read;
    if (t_op[i] == "I") begin
      @(posedge clk0);
      usr_rd_strb <= 1'b1;
      usr_addr    <= t_addr[i];
      @(posedge clk0);
      if (phy_rdy) begin
        $display("test %s: phy_rdy was already high, early read not exercised", t_name[i]);
        errors++;
      end
      usr_rd_strb <= 1'b0;
      return;
    end
    if (!phy_rdy) wait_ready();
    if (cal_bad) return;
    @(posedge clk0);
    usr_addr <= t_addr[i];
    if (cmd == qdrc_usr_pkg::cmd_write) begin
      usr_wr_strb <= 1'b1;
      usr_rd_strb <= 1'b0;
      usr_wr_data <= t_data[i];
      usr_wr_be   <= t_be[i];
      if (t_addr[i] == '0) zero_written = 1'b1;
      @(posedge clk0);
      usr_wr_strb <= 1'b0; // keeps writes off consecutive cycles.
      $display("test %s: write issued", t_name[i]);
    end else begin
      usr_rd_strb <= 1'b1; // left high so reads run back to back.
      usr_wr_strb <= 1'b0;
      exp_q.push_back((t_addr[i] == '0 && !zero_written) ? `QDRC_CAL_PATTERN : t_exp[i]);
      name_q.push_back(t_name[i]);
    end
  endtask

  // ********************************************************************
  // scoreboard, watchdog and main sequence
  // ********************************************************************

  always @(posedge clk0) begin
    if (usr_rd_dvld === 1'b1) check_read(usr_rd_data);
  end

  initial begin
    wait (loaded);
    #(2000 + 400 * n_tests);
    $display("run timed out before all reads came back");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    load_tests();
    loaded = 1'b1;
    repeat (4) @(posedge clk0);
    compare_bit("qdr_w_n", qdr_w_n, 1'b1);
    compare_bit("qdr_r_n", qdr_r_n, 1'b1);
    compare_bit("qdr_dll_off_n", qdr_dll_off_n, 1'b0);
    compare_bit("phy_rdy", phy_rdy, 1'b0);
    compare_bit("cal_fail", cal_fail, 1'b0);
    compare_bit("usr_rd_dvld", usr_rd_dvld, 1'b0);
    $display("test reset_state: %s", (errors == 0) ? "passed" : "failed");
    reset <= 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      if (!cal_bad) run_test(i);
    end
    @(posedge clk0);
    usr_rd_strb <= 1'b0;
    usr_wr_strb <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk0);
    // quiet window longer than the slowest read, to catch extra beats.
    repeat (`QDRC_CAL_MAX_LAT + 4) @(posedge clk0);
    for (int i = 0; i < n_tests; i++) begin
      if (t_op[i] == "I") begin
        $display("test %s: %s", t_name[i], (stray_beats == 0) ? "passed" :
                 "failed, data came back for a read issued before phy_rdy");
      end
    end
    if (cal_fail) begin
      $display("cal_fail is high at the end of the run");
      errors++;
    end
    if (dut.qdrc_checker_inst.assert_errors != 0) begin
      $display("%0d checker assertions failed", dut.qdrc_checker_inst.assert_errors);
      errors += dut.qdrc_checker_inst.assert_errors;
    end
    $display("%0d tests, %0d reads checked, %0d errors", n_tests, reads_checked, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- dv/qdrc_tests.txt
# name op addr data be expected, all numbers hex, data and expected are 36-bit words
# op W writes, R reads and compares, I reads before phy_rdy and expects no data back
early_rd_a I 000010 000000000 0 000000000
early_rd_b I 000000 000000000 0 000000000
cal_rd     R 000000 000000000 0 5a5a5a5a5
wr_a       W 000010 123456789 f 000000000
wr_b       W 000020 0abcdef01 f 000000000
wr_c       W 1fffff 987654321 f 000000000
rd_a       R 000010 000000000 0 123456789
rd_b       R 000020 000000000 0 0abcdef01
rd_c       R 1fffff 000000000 0 987654321
rd_a_again R 000010 000000000 0 123456789
part_a     W 000010 fffffffff 1 000000000
part_b     W 000020 000000000 a 000000000
rd_part_a  R 000010 000000000 0 1234567ff
rd_part_b  R 000020 000000000 0 003cc0101
wr_zero    W 000000 13579bdf0 f 000000000
rd_zero    R 000000 000000000 0 13579bdf0
rd_c_again R 1fffff 000000000 0 987654321

//--- qdrc.f
+incdir+logic
logic/qdrc_mem_pkg.sv
logic/qdrc_usr_pkg.sv
logic/qdrc_wr.sv
logic/qdrc_rd.sv
logic/qdrc_phy.sv
logic/qdrc_top.sv
dv/qdr_sram_model.sv
dv/qdrc_checker.sv
dv/qdrc_tb.sv

//--- Bender.yml
package:
  name: qdrc

export_include_dirs:
  - logic

sources:
  - logic/qdrc_mem_pkg.sv
  - logic/qdrc_usr_pkg.sv
  - logic/qdrc_wr.sv
  - logic/qdrc_rd.sv
  - logic/qdrc_phy.sv
  - logic/qdrc_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/qdr_sram_model.sv
      - dv/qdrc_checker.sv
      - dv/qdrc_tb.sv
